// ==== async_fifo_pkg.sv ====
package async_fifo_pkg;

    // geometry. depth must stay a power of two.
    localparam int ADDR_WIDTH = 3;
    localparam int DEPTH      = 2 ** ADDR_WIDTH;
    localparam int DATA_WIDTH = 8;

    // almost full at DEPTH - margin or more.
    localparam int ALMOST_FULL_MARGIN  = 1;
    // almost empty from 1 up to the margin.
    localparam int ALMOST_EMPTY_MARGIN = 1;

    // pointer with one extra wrap bit in binary or gray form.
    typedef logic [ADDR_WIDTH:0] ptr_t;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // flags owned by the write clock.
    typedef struct packed {
        logic full;
        logic almost_full;
    } wr_status_t;

    // flags owned by the read clock.
    typedef struct packed {
        logic                empty;
        logic                almost_empty;
        logic [ADDR_WIDTH:0] count;    // reaches DEPTH when full.
    } rd_status_t;

endpackage : async_fifo_pkg

// ==== fifo_wr_side.sv ====
`timescale 1ns/1ps

module fifo_wr_side
    import async_fifo_pkg::*;
(
    input  logic i_wr_clk,
    input  logic i_wr_rst_n,
    input  logic i_wr_en,
    input  logic i_full,
    output ptr_t o_wr_ptr_bin,
    output ptr_t o_wr_ptr_next,
    output ptr_t o_wr_ptr_gray,
    output logic o_mem_we
);

    logic wr_accept;
    ptr_t wr_ptr_bin;
    ptr_t wr_ptr_next;
    ptr_t wr_ptr_gray;

    // writes into a full fifo are dropped.
    assign wr_accept = i_wr_en & ~i_full;

    // lookahead pointer feeds the flag logic.
    assign wr_ptr_next = wr_ptr_bin + ptr_t'(wr_accept);

    always_ff @(posedge i_wr_clk or negedge i_wr_rst_n) begin
        if (!i_wr_rst_n) begin
            wr_ptr_bin  <= '0;
            wr_ptr_gray <= '0;
        end else begin
            wr_ptr_bin  <= wr_ptr_next;
            // gray copy is registered so only one bit moves per edge.
            wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
        end
    end

    assign o_wr_ptr_bin  = wr_ptr_bin;   // also the memory write address.
    assign o_wr_ptr_next = wr_ptr_next;
    assign o_wr_ptr_gray = wr_ptr_gray;
    assign o_mem_we      = wr_accept;

endmodule : fifo_wr_side

// ==== fifo_ptr_sync.sv ====
`timescale 1ns/1ps

module fifo_ptr_sync
    import async_fifo_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  ptr_t i_ptr_gray,
    output ptr_t o_ptr_bin
);

    ptr_t sync_meta;    // first stage may go metastable.
    ptr_t sync_gray;
    ptr_t ptr_bin;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_meta <= '0;
            sync_gray <= '0;
        end else begin
            sync_meta <= i_ptr_gray;
            sync_gray <= sync_meta;
        end
    end

    // gray to binary from the msb down.
    always_comb begin
        ptr_bin[ADDR_WIDTH] = sync_gray[ADDR_WIDTH];
        for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
            ptr_bin[i] = ptr_bin[i+1] ^ sync_gray[i];
        end
    end

    assign o_ptr_bin = ptr_bin;

endmodule : fifo_ptr_sync

// ==== fifo_control.sv ====
`timescale 1ns/1ps

module fifo_control
    import async_fifo_pkg::*;
(
    input  logic       i_wr_clk,
    input  logic       i_wr_rst_n,
    input  logic       i_rd_clk,
    input  logic       i_rd_rst_n,
    input  ptr_t       i_wr_ptr_next,
    input  ptr_t       i_wdom_rd_ptr,
    input  ptr_t       i_rd_ptr_next,
    input  ptr_t       i_rdom_wr_ptr,
    output wr_status_t o_wr_status,
    output rd_status_t o_rd_status
);

    logic       wdom_wrap_diff;
    logic       rdom_wrap_diff;
    ptr_t       wdom_level;
    ptr_t       rdom_level;
    wr_status_t wr_status_d;
    rd_status_t rd_status_d;

    assign wdom_wrap_diff = i_wr_ptr_next[ADDR_WIDTH] ^ i_wdom_rd_ptr[ADDR_WIDTH];
    assign rdom_wrap_diff = i_rd_ptr_next[ADDR_WIDTH] ^ i_rdom_wr_ptr[ADDR_WIDTH];

    // occupancy seen from each side modulo 2*DEPTH.
    assign wdom_level = i_wr_ptr_next - i_wdom_rd_ptr;
    assign rdom_level = i_rdom_wr_ptr - i_rd_ptr_next;

    // full when the wrap bits differ and the addresses match.
    assign wr_status_d.full = wdom_wrap_diff &&
        (i_wr_ptr_next[ADDR_WIDTH-1:0] == i_wdom_rd_ptr[ADDR_WIDTH-1:0]);
    assign wr_status_d.almost_full =
        wdom_level >= ptr_t'(DEPTH - ALMOST_FULL_MARGIN);

    // empty when the wrap bits and the addresses both match.
    assign rd_status_d.empty = !rdom_wrap_diff &&
        (i_rd_ptr_next[ADDR_WIDTH-1:0] == i_rdom_wr_ptr[ADDR_WIDTH-1:0]);
    assign rd_status_d.almost_empty = (rdom_level != '0) &&
        (rdom_level <= ptr_t'(ALMOST_EMPTY_MARGIN));
    assign rd_status_d.count = rdom_level;

    // next pointers in, so each flag is exact once the pointer has moved.
    always_ff @(posedge i_wr_clk or negedge i_wr_rst_n) begin
        if (!i_wr_rst_n) begin
            o_wr_status <= '0;
        end else begin
            o_wr_status <= wr_status_d;
        end
    end

    always_ff @(posedge i_rd_clk or negedge i_rd_rst_n) begin
        if (!i_rd_rst_n) begin
            o_rd_status.empty        <= 1'b1;    // empty out of reset.
            o_rd_status.almost_empty <= 1'b0;
            o_rd_status.count        <= '0;
        end else begin
            o_rd_status <= rd_status_d;
        end
    end

endmodule : fifo_control

// ==== fifo_mem.sv ====
`timescale 1ns/1ps

module fifo_mem
    import async_fifo_pkg::*;
(
    input  logic  i_wr_clk,
    input  logic  i_rd_clk,
    input  logic  i_rd_rst_n,
    input  logic  i_we,
    input  ptr_t  i_waddr,
    input  data_t i_wdata,
    input  logic  i_re,
    input  ptr_t  i_raddr,
    output data_t o_rdata
);

    data_t mem [DEPTH];

    // wrap bit is dropped, low bits address the array.
    always_ff @(posedge i_wr_clk) begin
        if (i_we) begin
            mem[i_waddr[ADDR_WIDTH-1:0]] <= i_wdata;
        end
    end

    always_ff @(posedge i_rd_clk or negedge i_rd_rst_n) begin
        if (!i_rd_rst_n) begin
            o_rdata <= '0;
        end else if (i_re) begin
            o_rdata <= mem[i_raddr[ADDR_WIDTH-1:0]];    // holds between reads.
        end
    end

endmodule : fifo_mem

// ==== fifo_rd_side.sv ====
`timescale 1ns/1ps

module fifo_rd_side
    import async_fifo_pkg::*;
(
    input  logic i_rd_clk,
    input  logic i_rd_rst_n,
    input  logic i_rd_en,
    input  logic i_empty,
    output ptr_t o_rd_ptr_bin,
    output ptr_t o_rd_ptr_next,
    output ptr_t o_rd_ptr_gray,
    output logic o_mem_re,
    output logic o_rd_valid
);

    logic rd_accept;
    ptr_t rd_ptr_bin;
    ptr_t rd_ptr_next;
    ptr_t rd_ptr_gray;
    logic rd_valid;

    assign rd_accept   = i_rd_en & ~i_empty;    // reads on empty are ignored.
    assign rd_ptr_next = rd_ptr_bin + ptr_t'(rd_accept);

    always_ff @(posedge i_rd_clk or negedge i_rd_rst_n) begin
        if (!i_rd_rst_n) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
            rd_valid    <= 1'b0;
        end else begin
            rd_ptr_bin  <= rd_ptr_next;
            rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
            // same edge as the memory read register.
            rd_valid    <= rd_accept;
        end
    end

    assign o_rd_ptr_bin  = rd_ptr_bin;    // address of the word being read.
    assign o_rd_ptr_next = rd_ptr_next;
    assign o_rd_ptr_gray = rd_ptr_gray;
    assign o_mem_re      = rd_accept;
    assign o_rd_valid    = rd_valid;

endmodule : fifo_rd_side

// ==== async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo
    import async_fifo_pkg::*;
(
    input  logic                i_wr_clk,
    input  logic                i_wr_rst_n,
    input  logic                i_wr_en,
    input  data_t               i_wr_data,
    input  logic                i_rd_clk,
    input  logic                i_rd_rst_n,
    input  logic                i_rd_en,
    output data_t               o_rd_data,
    output logic                o_rd_valid,
    output logic                o_wr_full,
    output logic                o_wr_almost_full,
    output logic                o_rd_empty,
    output logic                o_rd_almost_empty,
    output logic [ADDR_WIDTH:0] o_rd_count
);

    ptr_t       wr_ptr_bin;
    ptr_t       wr_ptr_next;
    ptr_t       wr_ptr_gray;
    ptr_t       rd_ptr_bin;
    ptr_t       rd_ptr_next;
    ptr_t       rd_ptr_gray;
    ptr_t       wdom_rd_ptr;    // read pointer in write clock.
    ptr_t       rdom_wr_ptr;    // write pointer in read clock.
    logic       mem_we;
    logic       mem_re;
    wr_status_t wr_status;
    rd_status_t rd_status;

    fifo_wr_side fifo_wr_side_i (
        .i_wr_clk      (i_wr_clk),
        .i_wr_rst_n    (i_wr_rst_n),
        .i_wr_en       (i_wr_en),
        .i_full        (wr_status.full),
        .o_wr_ptr_bin  (wr_ptr_bin),
        .o_wr_ptr_next (wr_ptr_next),
        .o_wr_ptr_gray (wr_ptr_gray),
        .o_mem_we      (mem_we)
    );

    // write pointer into the read domain.
    fifo_ptr_sync wr_ptr_sync_i (
        .i_clk      (i_rd_clk),
        .i_rst_n    (i_rd_rst_n),
        .i_ptr_gray (wr_ptr_gray),
        .o_ptr_bin  (rdom_wr_ptr)
    );

    // read pointer into the write domain.
    fifo_ptr_sync rd_ptr_sync_i (
        .i_clk      (i_wr_clk),
        .i_rst_n    (i_wr_rst_n),
        .i_ptr_gray (rd_ptr_gray),
        .o_ptr_bin  (wdom_rd_ptr)
    );

    fifo_control fifo_control_i (
        .i_wr_clk      (i_wr_clk),
        .i_wr_rst_n    (i_wr_rst_n),
        .i_rd_clk      (i_rd_clk),
        .i_rd_rst_n    (i_rd_rst_n),
        .i_wr_ptr_next (wr_ptr_next),
        .i_wdom_rd_ptr (wdom_rd_ptr),
        .i_rd_ptr_next (rd_ptr_next),
        .i_rdom_wr_ptr (rdom_wr_ptr),
        .o_wr_status   (wr_status),
        .o_rd_status   (rd_status)
    );

    fifo_mem fifo_mem_i (
        .i_wr_clk   (i_wr_clk),
        .i_rd_clk   (i_rd_clk),
        .i_rd_rst_n (i_rd_rst_n),
        .i_we       (mem_we),
        .i_waddr    (wr_ptr_bin),
        .i_wdata    (i_wr_data),
        .i_re       (mem_re),
        .i_raddr    (rd_ptr_bin),
        .o_rdata    (o_rd_data)
    );

    fifo_rd_side fifo_rd_side_i (
        .i_rd_clk      (i_rd_clk),
        .i_rd_rst_n    (i_rd_rst_n),
        .i_rd_en       (i_rd_en),
        .i_empty       (rd_status.empty),
        .o_rd_ptr_bin  (rd_ptr_bin),
        .o_rd_ptr_next (rd_ptr_next),
        .o_rd_ptr_gray (rd_ptr_gray),
        .o_mem_re      (mem_re),
        .o_rd_valid    (o_rd_valid)
    );

    assign o_wr_full         = wr_status.full;
    assign o_wr_almost_full  = wr_status.almost_full;
    assign o_rd_empty        = rd_status.empty;
    assign o_rd_almost_empty = rd_status.almost_empty;
    assign o_rd_count        = rd_status.count;

endmodule : async_fifo

// ==== async_fifo_properties.sv ====
`timescale 1ns/1ps

module async_fifo_properties
    import async_fifo_pkg::*;
(
    input logic       i_wr_clk,
    input logic       i_wr_rst_n,
    input logic       i_rd_clk,
    input logic       i_rd_rst_n,
    input wr_status_t i_wr_status,
    input rd_status_t i_rd_status
);

    full_has_almost_full: assert property (@(posedge i_wr_clk) disable iff (!i_wr_rst_n)
        i_wr_status.full |-> i_wr_status.almost_full
    ) else $error("full is set while almost full is clear");

    // margins keep these two apart.
    empty_not_almost_empty: assert property (@(posedge i_rd_clk) disable iff (!i_rd_rst_n)
        !(i_rd_status.empty && i_rd_status.almost_empty)
    ) else $error("empty and almost empty are set together");

    count_zero_when_empty: assert property (@(posedge i_rd_clk) disable iff (!i_rd_rst_n)
        (i_rd_status.count == '0) == i_rd_status.empty
    ) else $error("count and empty disagree");

    count_within_depth: assert property (@(posedge i_rd_clk) disable iff (!i_rd_rst_n)
        i_rd_status.count <= (ADDR_WIDTH + 1)'(DEPTH)
    ) else $error("count is above the fifo depth");

endmodule : async_fifo_properties

bind fifo_control async_fifo_properties async_fifo_properties_i (
    .i_wr_clk    (i_wr_clk),
    .i_wr_rst_n  (i_wr_rst_n),
    .i_rd_clk    (i_rd_clk),
    .i_rd_rst_n  (i_rd_rst_n),
    .i_wr_status (o_wr_status),
    .i_rd_status (o_rd_status)
);

// ==== async_fifo_tb.sv ====
`timescale 1ns/1ps

module async_fifo_tb
    import async_fifo_pkg::*;
();

    localparam int RD_PERIOD     = 4;
    localparam int WR_PERIOD     = 6;    // write clock for the testbench only.
    localparam int RESET_CYCLES  = 5;
    localparam int SETTLE_CYCLES = 8;
    localparam int STEP_BUDGET   = 20;    // read cycles allowed per step.
    localparam logic [1:0] OP_SETTLE = 2'd0;
    localparam logic [1:0] OP_WRITE  = 2'd1;
    localparam logic [1:0] OP_READ   = 2'd2;
    localparam logic [1:0] OP_BOTH   = 2'd3;

    // one line of the step file.
    typedef struct packed {
        int                  test;
        logic [1:0]          op;
        data_t               data;
        logic [ADDR_WIDTH:0] count;
        logic                full;
        logic                almost_full;
        logic                empty;
        logic                almost_empty;
    } step_t;

    logic                wr_clk, wr_rst_n, wr_en;
    logic                rd_clk, rd_rst_n, rd_en;
    data_t               wr_data, rd_data;
    logic                rd_valid, wr_full, wr_almost_full, rd_empty, rd_almost_empty;
    logic [ADDR_WIDTH:0] rd_count;
    step_t               steps[$];
    data_t               model[$];    // words the DUT should still hold.
    int                  test_errs = 0;
    int                  total_errs = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    logic                loaded = 1'b0;

    async_fifo async_fifo_i (
        .i_wr_clk          (wr_clk),
        .i_wr_rst_n        (wr_rst_n),
        .i_wr_en           (wr_en),
        .i_wr_data         (wr_data),
        .i_rd_clk          (rd_clk),
        .i_rd_rst_n        (rd_rst_n),
        .i_rd_en           (rd_en),
        .o_rd_data         (rd_data),
        .o_rd_valid        (rd_valid),
        .o_wr_full         (wr_full),
        .o_wr_almost_full  (wr_almost_full),
        .o_rd_empty        (rd_empty),
        .o_rd_almost_empty (rd_almost_empty),
        .o_rd_count        (rd_count)
    );

    initial begin
        rd_clk = 1'b0;
        forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
    end

    initial begin
        wr_clk = 1'b0;
        forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic load_steps();
        int    fd;
        int    t, op, word, cnt, full, afull, empty, aempty;
        string line;
        step_t s;
        fd = $fopen("async_fifo_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the step file async_fifo_tests.txt");
            total_errs++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // comment lines do not scan into eight fields.
            if ($sscanf(line, "%d %d %h %d %d %d %d %d",
                        t, op, word, cnt, full, afull, empty, aempty) == 8) begin
                s.test         = t;
                s.op           = op[1:0];
                s.data         = word[DATA_WIDTH-1:0];
                s.count        = cnt[ADDR_WIDTH:0];
                s.full         = full[0];
                s.almost_full  = afull[0];
                s.empty        = empty[0];
                s.almost_empty = aempty[0];
                steps.push_back(s);
            end
        end
        $fclose(fd);
    endtask

    task automatic write_word(input data_t word);
        @(posedge wr_clk);
        #1;
        wr_en   = 1'b1;
        wr_data = word;
        if (model.size() < DEPTH) begin
            model.push_back(word);    // a full fifo drops the word.
        end
        @(posedge wr_clk);
        #1 wr_en = 1'b0;
    endtask

    task automatic read_word();
        @(posedge rd_clk);
        #1 rd_en = 1'b1;
        @(posedge rd_clk);
        #1 rd_en = 1'b0;
    endtask

    // idle long enough for both synchronizers, then compare flags.
    task automatic settle_and_check(input step_t s);
        repeat (SETTLE_CYCLES) @(posedge rd_clk);
        @(negedge rd_clk);
        check_value("o_rd_count", 32'(s.count), 32'(rd_count));
        check_value("o_wr_full", 32'(s.full), 32'(wr_full));
        check_value("o_wr_almost_full", 32'(s.almost_full), 32'(wr_almost_full));
        check_value("o_rd_empty", 32'(s.empty), 32'(rd_empty));
        check_value("o_rd_almost_empty", 32'(s.almost_empty), 32'(rd_almost_empty));
        assert (model.size() == int'(s.count)) else begin
            $display("test %0d: the reference queue holds %0d words but the step expects %0d",
                     s.test, model.size(), s.count);
            test_errs++;
        end
    endtask

    task automatic close_test(input int test);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d finished, no errors", test);
        end else begin
            $display("test %0d finished, %0d errors", test, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    // read data is stable at the falling edge.
    always @(negedge rd_clk) begin
        if (rd_rst_n && rd_valid) begin
            assert (model.size() != 0) else begin
                $display("o_rd_valid pulsed at %0t ns while no word was expected", $time);
                test_errs++;
            end
            if (model.size() != 0) begin
                check_value("o_rd_data", 32'(model.pop_front()), 32'(rd_data));
            end
        end
    end

    initial begin
        wait (loaded);
        #(steps.size() * STEP_BUDGET * RD_PERIOD);
        $display("timeout: the steps did not complete within %0d read cycles",
                 steps.size() * STEP_BUDGET);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        wr_en    = 1'b0;
        wr_data  = '0;
        rd_en    = 1'b0;
        wr_rst_n = 1'b0;
        rd_rst_n = 1'b0;
        load_steps();
        loaded = 1'b1;
        fork
            begin
                repeat (RESET_CYCLES) @(posedge wr_clk);
                #1 wr_rst_n = 1'b1;
            end
            begin
                repeat (RESET_CYCLES) @(posedge rd_clk);
                #1 rd_rst_n = 1'b1;
            end
        join
        foreach (steps[i]) begin
            if (i > 0 && steps[i].test != steps[i-1].test) begin
                close_test(steps[i-1].test);
            end
            case (steps[i].op)
                OP_SETTLE: settle_and_check(steps[i]);
                OP_WRITE:  write_word(steps[i].data);
                OP_READ:   read_word();
                OP_BOTH: begin
                    fork
                        write_word(steps[i].data);
                        read_word();
                    join
                end
            endcase
        end
        if (steps.size() != 0) begin
            close_test(steps[$].test);
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
        if (total_errs == 0 && tests_run != 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : async_fifo_tb

// ==== async_fifo_tests.txt ====
# test op data(hex) count full almost_full empty almost_empty
# op: 0 settle, 1 write, 2 read, 3 write and read; count and flags checked on settle only
1 0 00 0 0 0 1 0
2 1 11 0 0 0 0 0
2 1 12 0 0 0 0 0
2 1 13 0 0 0 0 0
2 1 14 0 0 0 0 0
2 1 15 0 0 0 0 0
2 1 16 0 0 0 0 0
2 1 17 0 0 0 0 0
2 1 18 0 0 0 0 0
2 0 00 8 1 1 0 0
2 1 99 0 0 0 0 0
3 2 00 0 0 0 0 0
3 0 00 7 0 1 0 0
3 2 00 0 0 0 0 0
3 2 00 0 0 0 0 0
3 2 00 0 0 0 0 0
3 2 00 0 0 0 0 0
3 2 00 0 0 0 0 0
3 2 00 0 0 0 0 0
3 0 00 1 0 0 0 1
3 2 00 0 0 0 0 0
3 0 00 0 0 0 1 0
4 2 00 0 0 0 0 0
4 0 00 0 0 0 1 0
5 1 a1 0 0 0 0 0
5 1 a2 0 0 0 0 0
5 3 a3 0 0 0 0 0
5 3 a4 0 0 0 0 0
5 0 00 2 0 0 0 0
5 2 00 0 0 0 0 0
5 2 00 0 0 0 0 0
5 0 00 0 0 0 1 0

// ==== async_fifo.f ====
async_fifo_pkg.sv
fifo_wr_side.sv
fifo_ptr_sync.sv
fifo_control.sv
fifo_mem.sv
fifo_rd_side.sv
async_fifo.sv
async_fifo_properties.sv
async_fifo_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= async_fifo_tb
FILELIST  ?= async_fifo.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes.
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) async_fifo_tests.txt
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^Simulation PASSED$$' $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
